//--- all.f
+incdir+verilog
verilog/wht_pkg.sv
verilog/wht_butterfly_stage.sv
verilog/wht_hard_threshold.sv
verilog/wht_denoise_top.sv
verif/tb_clock_gen.sv
verif/tb_wht_denoise.sv

//--- Makefile
# Verilator build and run of the WHT denoiser testbench
# override any variable on the command line, e.g. make run LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_wht_denoise
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)

PASS_MSG  := === PASS ===
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator exit status is ignored, the log decides
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_wht_denoise.sv
// testbench for the WHT denoiser; runs all tests and prints a per-test line and a summary
`include "wht_settings.svh"

module tb_wht_denoise;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS = 40;
    localparam int PIX_MAX       = (1 << (`WHT_PIX_W - 1)) - 1;
    localparam int PIX_MIN       = -(1 << (`WHT_PIX_W - 1));
    localparam int CONST_PIX     = -300;
    localparam int IMPULSE       = 1000;
    localparam int N_RAND        = 200;
    localparam int N_EXTREME     = 6;
    localparam int N_GAP         = 60;
    localparam int MAX_GAP       = 4;
    localparam int TOTAL_COLS    = 1 + N_RAND + 3 + N_EXTREME + N_GAP;
    // worst case per drain: one edge, ten waiting cycles, tail and a threshold load
    localparam int MAX_DRAINS    = 16;
    localparam int DRAIN_CYCLES  = 18;
    localparam int WATCHDOG_CYCLES = 2 + 10 + TOTAL_COLS + N_GAP * MAX_GAP
                                     + MAX_DRAINS * DRAIN_CYCLES + 20;

    logic                  clk;
    logic                  rst_n;
    wht_pkg::thresh_t      hard_th;
    wht_pkg::col_in_t      col_in;
    wht_pkg::col_out_t     col_out;

    wht_pkg::col_out_t     exp_q[$];
    string                 test_name = "none";
    int                    errors = 0;
    int                    test_err_base = 0;
    int                    test_sent = 0;
    int                    test_recv = 0;
    int                    tests_passed = 0;
    int                    tests_failed = 0;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (2)
    ) u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    wht_denoise_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .hard_th (hard_th),
        .col_in  (col_in),
        .col_out (col_out)
    );

    // expected column straight from the transform sum and the threshold rule
    function automatic wht_pkg::col_out_t wht_ref(input wht_pkg::col_in_t col,
                                                   input wht_pkg::thresh_t th);
        wht_pkg::col_out_t r;
        int sum;
        int mag;
        int kept;
        r = '0;
        r.valid = 1'b1;
        kept = 0;
        for (int k = 0; k < `WHT_POINTS; k++) begin
            sum = 0;
            for (int j = 0; j < `WHT_POINTS; j++) begin
                if (($countones(k & j) % 2) != 0) begin
                    sum = sum - int'(col.pix[j]);
                end else begin
                    sum = sum + int'(col.pix[j]);
                end
            end
            mag = (sum < 0) ? -sum : sum;
            if (mag > int'(th)) begin
                r.coef[k] = wht_pkg::coef_t'(sum);
                kept++;
            end
        end
        r.kept_cnt = wht_pkg::kept_cnt_t'(kept);
        return r;
    endfunction

    function automatic wht_pkg::col_in_t random_column();
        wht_pkg::col_in_t c;
        c.valid = 1'b1;
        for (int j = 0; j < `WHT_POINTS; j++) begin
            c.pix[j] = wht_pkg::pix_t'($urandom);
        end
        return c;
    endfunction

    // full-scale patterns that push every stage to its widest sums
    function automatic wht_pkg::col_in_t extreme_column(input int pat);
        wht_pkg::col_in_t c;
        bit hi;
        c.valid = 1'b1;
        for (int j = 0; j < `WHT_POINTS; j++) begin
            case (pat)
                0:       hi = 1'b0;
                1:       hi = 1'b1;
                2:       hi = (j % 2) != 0;
                3:       hi = (j % 2) == 0;
                4:       hi = (j & 4) == 0;
                default: hi = ($countones(j) % 2) == 0;
            endcase
            c.pix[j] = hi ? wht_pkg::pix_t'(PIX_MAX) : wht_pkg::pix_t'(PIX_MIN);
        end
        return c;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    task automatic check_coef(input string name, input int idx,
                              input wht_pkg::coef_t expected, input wht_pkg::coef_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s coef[%0d]: expected %0d, actual %0d",
                     name, idx, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input wht_pkg::kept_cnt_t expected,
                               input wht_pkg::kept_cnt_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s kept_cnt: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic drive_column(input wht_pkg::col_in_t c, input wht_pkg::col_out_t e);
        @(posedge clk);
        col_in <= c;
        exp_q.push_back(e);
        test_sent++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            col_in.valid <= 1'b0;
        end
    endtask

    // only called with the pipeline empty, the thresholder samples it late
    task automatic set_threshold(input wht_pkg::thresh_t th);
        @(posedge clk);
        col_in.valid <= 1'b0;
        hard_th <= th;
    endtask

    task automatic drain_pipe();
        int waited;
        waited = 0;
        @(posedge clk);
        col_in.valid <= 1'b0;
        while (exp_q.size() != 0 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_error($sformatf("%0d columns never came out of the pipeline", exp_q.size()));
            exp_q.delete();
        end
        // tail catches any extra output column
        repeat (6) @(negedge clk);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err_base = errors;
        test_sent = 0;
        test_recv = 0;
    endtask

    task automatic finish_test();
        drain_pipe();
        if (test_recv != test_sent) begin
            report_error($sformatf("%0d columns sent but %0d came out", test_sent, test_recv));
        end
        if (errors == test_err_base) begin
            tests_passed++;
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - test_err_base);
        end
    endtask

    // outputs settle after the rising edge, compare on the falling one
    always @(negedge clk) begin : compare_outputs
        wht_pkg::col_out_t exp;
        if (rst_n && col_out.valid) begin
            test_recv++;
            if (exp_q.size() == 0) begin
                report_error("output column appeared with no input column in flight");
            end else begin
                exp = exp_q.pop_front();
                for (int i = 0; i < `WHT_POINTS; i++) begin
                    check_coef(test_name, i, exp.coef[i], col_out.coef[i]);
                end
                check_count(test_name, exp.kept_cnt, col_out.kept_cnt);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : run_tests
        wht_pkg::col_in_t  c;
        wht_pkg::col_out_t e;
        wht_pkg::thresh_t  th;
        int                n;
        bit                seen;
        int                gap;
        col_in  = '0;
        hard_th = '0;
        void'($urandom(27));
        wait (rst_n === 1'b1);

        start_test("reset_idle");
        repeat (10) begin
            @(negedge clk);
            if (col_out.valid !== 1'b0) begin
                report_error("col_out.valid is not low while idle after reset");
            end
        end
        finish_test();

        start_test("constant_column");
        set_threshold('0);
        c = '0;
        c.valid = 1'b1;
        for (int j = 0; j < `WHT_POINTS; j++) begin
            c.pix[j] = wht_pkg::pix_t'(CONST_PIX);
        end
        e = '0;
        e.valid = 1'b1;
        e.coef[0] = wht_pkg::coef_t'(`WHT_POINTS * CONST_PIX);
        e.kept_cnt = wht_pkg::kept_cnt_t'(1);
        drive_column(c, e);
        // edge 1 is the one that samples the column
        n = 0;
        seen = 1'b0;
        while (!seen && n < 10) begin
            @(posedge clk);
            n++;
            if (n == 1) begin
                col_in.valid <= 1'b0;
            end
            @(negedge clk);
            seen = col_out.valid;
        end
        if (!seen) begin
            report_error("no output column within 10 cycles");
        end else if (n != 5) begin
            errors++;
            $display("Mismatch %s latency: expected 5, actual %0d", test_name, n);
        end
        finish_test();

        start_test("back_to_back");
        th = wht_pkg::thresh_t'($urandom_range(0, 8000));
        set_threshold(th);
        repeat (N_RAND) begin
            c = random_column();
            drive_column(c, wht_ref(c, th));
        end
        finish_test();

        // impulse, so every coefficient equals the single pixel
        start_test("threshold_boundary");
        c = '0;
        c.valid = 1'b1;
        c.pix[0] = wht_pkg::pix_t'(IMPULSE);
        set_threshold(wht_pkg::thresh_t'(IMPULSE));
        e = '0;
        e.valid = 1'b1;
        drive_column(c, e);
        drain_pipe();
        set_threshold(wht_pkg::thresh_t'(IMPULSE - 1));
        e.kept_cnt = wht_pkg::kept_cnt_t'(`WHT_POINTS);
        for (int k = 0; k < `WHT_POINTS; k++) begin
            e.coef[k] = wht_pkg::coef_t'(IMPULSE);
        end
        drive_column(c, e);
        c.pix[0] = wht_pkg::pix_t'(-IMPULSE);
        for (int k = 0; k < `WHT_POINTS; k++) begin
            e.coef[k] = wht_pkg::coef_t'(-IMPULSE);
        end
        drive_column(c, e);
        finish_test();

        start_test("extreme_pixels");
        set_threshold('0);
        for (int p = 0; p < N_EXTREME; p++) begin
            c = extreme_column(p);
            drive_column(c, wht_ref(c, '0));
        end
        finish_test();

        start_test("random_gaps");
        th = wht_pkg::thresh_t'($urandom_range(0, 8000));
        set_threshold(th);
        for (int i = 0; i < N_GAP; i++) begin
            if (i > 0 && (i % 15) == 0) begin
                drain_pipe();
                th = wht_pkg::thresh_t'($urandom_range(0, 8000));
                set_threshold(th);
            end
            c = random_column();
            drive_column(c, wht_ref(c, th));
            gap = $urandom_range(0, MAX_GAP);
            idle_cycles(gap);
        end
        finish_test();

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
// testbench clock and reset source; instantiate once in the testbench top
module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge, away from the DUT sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- verilog/wht_denoise_top.sv
// 16-point WHT denoiser top, five-cycle fixed latency, one column per cycle
`include "wht_settings.svh"

module wht_denoise_top (
    input  logic               clk,
    input  logic               rst_n,
    input  wht_pkg::thresh_t   hard_th,
    input  wht_pkg::col_in_t   col_in,
    output wht_pkg::col_out_t  col_out
);

    // input column widened to coefficient width
    wht_pkg::stage_t col_wide;

    // outputs of the four butterfly stages
    wht_pkg::stage_t stg1;
    wht_pkg::stage_t stg2;
    wht_pkg::stage_t stg3;
    wht_pkg::stage_t stg4;

    // sign extension, pix_t is signed so the cast extends the sign bit
    always_comb begin
        col_wide.valid = col_in.valid;
        for (int i = 0; i < `WHT_POINTS; i++) begin
            col_wide.coef[i] = wht_pkg::coef_t'(col_in.pix[i]);
        end
    end

    wht_butterfly_stage #(
        .SPAN (1)
    ) u_stage0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .stage_in  (col_wide),
        .stage_out (stg1)
    );

    wht_butterfly_stage #(
        .SPAN (2)
    ) u_stage1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .stage_in  (stg1),
        .stage_out (stg2)
    );

    wht_butterfly_stage #(
        .SPAN (4)
    ) u_stage2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .stage_in  (stg2),
        .stage_out (stg3)
    );

    wht_butterfly_stage #(
        .SPAN (8)
    ) u_stage3 (
        .clk       (clk),
        .rst_n     (rst_n),
        .stage_in  (stg3),
        .stage_out (stg4)
    );

    // coefficients arrive in natural Hadamard order
    wht_hard_threshold u_threshold (
        .clk     (clk),
        .rst_n   (rst_n),
        .hard_th (hard_th),
        .coefs   (stg4),
        .col_out (col_out)
    );

endmodule

//--- verilog/wht_hard_threshold.sv
// hard thresholding of one transformed column, counts kept coefficients, one cycle
`include "wht_settings.svh"

module wht_hard_threshold (
    input  logic               clk,
    input  logic               rst_n,
    input  wht_pkg::thresh_t   hard_th,
    input  wht_pkg::stage_t    coefs,
    output wht_pkg::col_out_t  col_out
);

    localparam int NODES = 2 * `WHT_POINTS - 1;

    logic [`WHT_COEF_W-1:0]  mag [`WHT_POINTS];
    logic [`WHT_POINTS-1:0]  keep;

    // root of the adder tree over the keep flags
    wht_pkg::kept_cnt_t      kept_sum;

    // number of nonzero coefficients in a registered column
    function automatic wht_pkg::kept_cnt_t nonzero_cnt(input wht_pkg::col_out_t blk);
        wht_pkg::kept_cnt_t n;
        n = '0;
        for (int i = 0; i < `WHT_POINTS; i++) begin
            if (blk.coef[i] != '0) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    genvar i;
    generate
        for (i = 0; i < `WHT_POINTS; i = i + 1) begin : g_mag
            // full width magnitude, the most negative sum still fits unsigned
            assign mag[i] = coefs.coef[i][`WHT_COEF_W-1] ? $unsigned(-coefs.coef[i])
                                                       : $unsigned(coefs.coef[i]);
            assign keep[i] = mag[i] > {1'b0, hard_th};
        end
    endgenerate

    // heap-ordered adder tree, leaves from POINTS-1 up, root at 0
    always_comb begin
        wht_pkg::kept_cnt_t node [NODES];
        for (int n = 0; n < `WHT_POINTS; n++) begin
            node[`WHT_POINTS-1+n] = wht_pkg::kept_cnt_t'(keep[n]);
        end
        for (int n = `WHT_POINTS - 2; n >= 0; n--) begin
            node[n] = node[2*n+1] + node[2*n+2];
        end
        kept_sum = node[0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_out <= '0;
        end else begin
            col_out.valid <= coefs.valid;
            if (coefs.valid) begin
                for (int k = 0; k < `WHT_POINTS; k++) begin
                    col_out.coef[k] <= keep[k] ? coefs.coef[k] : '0;
                end
                col_out.kept_cnt <= kept_sum;
            end
        end
    end

    // never more kept than there are points
    a_cnt_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        col_out.kept_cnt <= `WHT_POINTS
    ) else $error("kept count %0d exceeds block size", col_out.kept_cnt);

    // count must match the surviving coefficients, so no zeroed entry is counted
    a_cnt_matches: assert property (
        @(posedge clk) disable iff (!rst_n)
        col_out.valid |-> col_out.kept_cnt == nonzero_cnt(col_out)
    ) else $error("kept count %0d disagrees with nonzero outputs %0d",
                  col_out.kept_cnt, nonzero_cnt(col_out));

endmodule

//--- verilog/wht_butterfly_stage.sv
// one registered radix-2 WHT stage; instantiate once per span 1, 2, 4, 8
`include "wht_settings.svh"

module wht_butterfly_stage #(
    parameter int SPAN = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  wht_pkg::stage_t  stage_in,
    output wht_pkg::stage_t  stage_out
);

    localparam int PAIRS = `WHT_POINTS / 2;

    // next value of every element, sum on the low index, difference on the high
    wht_pkg::coef_t [`WHT_POINTS-1:0] bfly;

    genvar p;
    generate
        for (p = 0; p < PAIRS; p = p + 1) begin : g_pair
            // low index has bit SPAN clear
            localparam int LO = (p / SPAN) * 2 * SPAN + (p % SPAN);
            localparam int HI = LO + SPAN;

            assign bfly[LO] = stage_in.coef[LO] + stage_in.coef[HI];
            assign bfly[HI] = stage_in.coef[LO] - stage_in.coef[HI];
        end
    endgenerate

    // valid follows input every cycle, data only loads on a valid column
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_out <= '0;
        end else begin
            stage_out.valid <= stage_in.valid;
            if (stage_in.valid) begin
                stage_out.coef <= bfly;
            end
        end
    end

    // downstream stages load on this flag, an X here corrupts the rest of the pipe
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(stage_out.valid)
    ) else $error("butterfly stage span %0d: valid is unknown", SPAN);

endmodule

//--- verilog/wht_pkg.sv
// types shared by the WHT pipeline and its testbench, used by scoped name
`include "wht_settings.svh"

package wht_pkg;

    // signed input pixel
    typedef logic signed [`WHT_PIX_W-1:0] pix_t;

    // signed transform coefficient, full output width
    typedef logic signed [`WHT_COEF_W-1:0] coef_t;

    // unsigned magnitude threshold
    typedef logic [`WHT_TH_W-1:0] thresh_t;

    // number of coefficients kept in one block
    typedef logic [`WHT_CNT_W-1:0] kept_cnt_t;

    // one input column
    typedef struct packed {
        logic                         valid;
        pix_t [`WHT_POINTS-1:0]       pix;
    } col_in_t;

    // column between butterfly stages and into the thresholder
    typedef struct packed {
        logic                         valid;
        coef_t [`WHT_POINTS-1:0]      coef;
    } stage_t;

    // denoised column with its kept count
    typedef struct packed {
        logic                         valid;
        coef_t [`WHT_POINTS-1:0]      coef;
        kept_cnt_t                    kept_cnt;
    } col_out_t;

endpackage

//--- verilog/wht_settings.svh
// sizes and widths of the WHT denoiser; include wherever the macros are needed
`ifndef WHT_SETTINGS_SVH
`define WHT_SETTINGS_SVH

// pixels per column
`define WHT_POINTS 16

// radix-2 stages, log2 of the point count
`define WHT_STAGES 4

// input pixel, sign bit plus 12 integer bits
`define WHT_PIX_W 13

// one bit of growth per stage, so no stage can overflow
`define WHT_COEF_W (`WHT_PIX_W + `WHT_STAGES)

// unsigned threshold on coefficient magnitude
`define WHT_TH_W 16

// kept count, 0 to 16
`define WHT_CNT_W 5

`endif
